// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_sfm_accumulator
FILELIST   := sfm_accumulator.f
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Everything OK
FAIL_MSG   := Something failed

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sfm_accumulator.f ====
src/sfm_acc_pkg.sv
src/sfm_acc_sum.sv
src/sfm_acc_recip_seed.sv
src/sfm_acc_mul_pipe.sv
src/sfm_acc_newton.sv
src/sfm_acc_ctrl.sv
src/sfm_accumulator.sv
tests/tb_sfm_accumulator.sv

// ==== src/sfm_acc_ctrl.sv ====
// ---------------------------------------------------------------------------
// finish_i counts only while accumulating. acc_only_i is taken with it
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sfm_acc_ctrl import sfm_acc_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic clear_i,
    input  logic add_valid_i,
    input  logic finish_i,
    input  logic acc_only_i,
    input  logic inv_done_i,
    output logic ready_o,
    output logic acc_en_o,
    output logic start_new_o,
    output logic inv_start_o,
    output logic acc_done_o,
    output logic valid_o
);

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic       acc_only_q;
    logic       accept;
    logic       finish;

    assign finish      = (state_q == ST_ACCUMULATING) & finish_i;
    assign acc_en_o    = (state_q == ST_IDLE) | (state_q == ST_ACCUMULATING)
                       | (state_q == ST_DONE);
    // No term is taken in the finish cycle
    assign ready_o     = acc_en_o & ~finish;
    assign accept      = add_valid_i & ready_o;
    assign start_new_o = (state_q == ST_IDLE) | (state_q == ST_DONE);
    assign acc_done_o  = (state_q == ST_FINISHING);
    assign inv_start_o = (state_q == ST_FINISHING) & ~acc_only_q;
    assign valid_o     = (state_q == ST_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_DONE: begin
                if (accept) begin
                    state_d = ST_ACCUMULATING;
                end
            end
            ST_ACCUMULATING: begin
                if (finish) begin
                    state_d = ST_FINISHING;
                end
            end
            ST_FINISHING: state_d = acc_only_q ? ST_IDLE : ST_INVERTING;
            ST_INVERTING: begin
                if (inv_done_i) begin
                    state_d = ST_DONE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ST_IDLE;
            acc_only_q <= 1'b0;
        end else if (clear_i) begin
            state_q    <= ST_IDLE;
            acc_only_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (finish) begin
                acc_only_q <= acc_only_i;
            end
        end
    end

endmodule

// ==== src/sfm_acc_mul_pipe.sv ====
// ---------------------------------------------------------------------------
// Q16.16 product, truncated and saturated. Needs MUL_STAGES of 2 or more
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sfm_acc_mul_pipe import sfm_acc_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        valid_i,
    input  fixed_word_u a_i,
    input  fixed_word_u b_i,
    output logic        valid_o,
    output fixed_word_u p_o
);

    logic [Q_WIDTH-1:0]    a_q;
    logic [Q_WIDTH-1:0]    b_q;
    logic [2*Q_WIDTH-1:0]  prod;
    logic [Q_WIDTH-1:0]    scaled;
    logic [Q_WIDTH-1:0]    res_q [MUL_STAGES-1];
    logic [MUL_STAGES-1:0] vld_q;

    assign prod = a_q * b_q;

    // Drop the low fraction bits, clip anything above the integer range
    assign scaled = (prod[2*Q_WIDTH-1:Q_WIDTH+FRAC_BITS] != '0) ? Q_MAX
                  : prod[Q_WIDTH+FRAC_BITS-1:FRAC_BITS];

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            a_q <= a_i.raw;
            b_q <= b_i.raw;
        end
        res_q[0] <= scaled;
        for (int i = 1; i < MUL_STAGES - 1; i++) begin
            res_q[i] <= res_q[i-1];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q <= '0;
        end else if (clear_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MUL_STAGES-2:0], valid_i};
        end
    end

    assign valid_o = vld_q[MUL_STAGES-1];
    assign p_o.raw = res_q[MUL_STAGES-2];

endmodule

// ==== src/sfm_acc_newton.sv ====
// ---------------------------------------------------------------------------
// x <- x*(2 - d*x), one product in flight. den_i must hold during the run
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sfm_acc_newton import sfm_acc_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        start_i,
    input  fixed_word_u den_i,
    output logic        done_o,
    output fixed_word_u recip_o
);

    logic [2:0]                phase_q;
    logic [ITER_CNT_WIDTH-1:0] iter_q;
    logic                      done_q;
    logic                      last_iter;
    logic                      mul_valid;
    logic                      prod_valid;
    fixed_word_u               seed;
    fixed_word_u               x_q;
    fixed_word_u               diff_q;
    fixed_word_u               mul_a;
    fixed_word_u               mul_b;
    fixed_word_u               prod;

    sfm_acc_recip_seed u_seed (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .start_i (start_i),
        .den_i   (den_i),
        .seed_o  (seed)
    );

    // Operand select, d*x by default
    always_comb begin
        mul_valid = 1'b0;
        mul_a     = den_i;
        mul_b     = x_q;
        case (phase_q)
            NR_SEED: begin
                mul_valid = 1'b1;
                mul_b     = seed;
            end
            NR_ISSUE_DX: mul_valid = 1'b1;
            NR_ISSUE_XD: begin
                mul_valid = 1'b1;
                mul_a     = x_q;
                mul_b     = diff_q;
            end
            default: mul_valid = 1'b0;
        endcase
    end

    sfm_acc_mul_pipe u_mul (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (mul_valid),
        .a_i     (mul_a),
        .b_i     (mul_b),
        .valid_o (prod_valid),
        .p_o     (prod)
    );

    assign last_iter = (iter_q == ITER_CNT_WIDTH'(N_INV_ITERS - 1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q   <= NR_IDLE;
            iter_q    <= '0;
            done_q    <= 1'b0;
            x_q.raw   <= Q_ONE;
        end else if (clear_i) begin
            phase_q   <= NR_IDLE;
            iter_q    <= '0;
            done_q    <= 1'b0;
            x_q.raw   <= Q_ONE;
        end else begin
            done_q <= 1'b0;
            case (phase_q)
                NR_IDLE: begin
                    if (start_i) begin
                        phase_q <= NR_SEED;
                        iter_q  <= '0;
                    end
                end
                NR_SEED: begin
                    x_q     <= seed;
                    phase_q <= NR_WAIT_DX;
                end
                NR_ISSUE_DX: phase_q <= NR_WAIT_DX;
                NR_WAIT_DX: begin
                    if (prod_valid) begin
                        phase_q <= NR_ISSUE_XD;
                    end
                end
                NR_ISSUE_XD: phase_q <= NR_WAIT_XD;
                NR_WAIT_XD: begin
                    if (prod_valid) begin
                        x_q <= prod;
                        if (last_iter) begin
                            done_q  <= 1'b1;
                            phase_q <= NR_IDLE;
                        end else begin
                            iter_q  <= iter_q + 1'b1;
                            phase_q <= NR_ISSUE_DX;
                        end
                    end
                end
                default: phase_q <= NR_IDLE;
            endcase
        end
    end

    // Correction term 2 - d*x, floored at zero
    always_ff @(posedge clk_i) begin
        if ((phase_q == NR_WAIT_DX) && prod_valid) begin
            diff_q.raw <= (prod.raw > Q_TWO) ? '0 : Q_TWO - prod.raw;
        end
    end

    assign done_o  = done_q;
    assign recip_o = x_q;

endmodule

// ==== src/sfm_acc_pkg.sv ====
// ---------------------------------------------------------------------------
// Unsigned Q16.16 data throughout. Changing FRAC_BITS needs new seed constants
// ---------------------------------------------------------------------------
package sfm_acc_pkg;

    localparam int unsigned Q_WIDTH        = 32;
    localparam int unsigned FRAC_BITS      = 16;
    localparam int unsigned INT_BITS       = Q_WIDTH - FRAC_BITS;
    localparam int unsigned N_INV_ITERS    = 3;
    localparam int unsigned MUL_STAGES     = 3;
    localparam int unsigned ITER_CNT_WIDTH = 2;
    localparam int unsigned LEAD_WIDTH     = $clog2(Q_WIDTH);

    localparam logic [Q_WIDTH-1:0] Q_ONE = 32'h0001_0000;
    localparam logic [Q_WIDTH-1:0] Q_TWO = 32'h0002_0000;
    localparam logic [Q_WIDTH-1:0] Q_MAX = '1;

    // Seed line 48/17 - 32/17*m, mantissa leading one sits at bit 15
    localparam logic [Q_WIDTH-1:0]    SEED_C0  = 32'd185043;
    localparam logic [Q_WIDTH-1:0]    SEED_C1  = 32'd123362;
    localparam logic [LEAD_WIDTH-1:0] MANT_POS = LEAD_WIDTH'(FRAC_BITS - 1);

    // Controller states
    localparam logic [2:0] ST_IDLE         = 3'd0;
    localparam logic [2:0] ST_ACCUMULATING = 3'd1;
    localparam logic [2:0] ST_FINISHING    = 3'd2;
    localparam logic [2:0] ST_INVERTING    = 3'd3;
    localparam logic [2:0] ST_DONE         = 3'd4;

    // Newton sequencer phases
    localparam logic [2:0] NR_IDLE     = 3'd0;
    localparam logic [2:0] NR_SEED     = 3'd1;
    localparam logic [2:0] NR_WAIT_DX  = 3'd2;
    localparam logic [2:0] NR_ISSUE_XD = 3'd3;
    localparam logic [2:0] NR_WAIT_XD  = 3'd4;
    localparam logic [2:0] NR_ISSUE_DX = 3'd5;

    typedef union packed {
        logic [Q_WIDTH-1:0] raw;
        struct packed {
            logic [INT_BITS-1:0]  int_part;
            logic [FRAC_BITS-1:0] frac_part;
        } fld;
    } fixed_word_u;

endpackage

// ==== src/sfm_acc_recip_seed.sv ====
// ---------------------------------------------------------------------------
// First guess of 1/d, about 1/17 relative error. Zero or tiny d gives Q_MAX
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sfm_acc_recip_seed import sfm_acc_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        start_i,
    input  fixed_word_u den_i,
    output fixed_word_u seed_o
);

    logic [LEAD_WIDTH-1:0]        lead_pos;
    logic                         is_zero;
    logic [Q_WIDTH-1:0]           mant;
    logic [2*Q_WIDTH-1:0]         slope;
    logic [Q_WIDTH-1:0]           guess;
    logic [Q_WIDTH+FRAC_BITS-1:0] wide;
    fixed_word_u                  seed_d;
    fixed_word_u                  seed_q;

    // Leading one, searched in the integer field first
    always_comb begin
        lead_pos = '0;
        if (den_i.fld.int_part != '0) begin
            for (int i = 0; i < INT_BITS; i++) begin
                if (den_i.fld.int_part[i]) begin
                    lead_pos = LEAD_WIDTH'(FRAC_BITS + i);
                end
            end
        end else begin
            for (int i = 0; i < FRAC_BITS; i++) begin
                if (den_i.fld.frac_part[i]) begin
                    lead_pos = LEAD_WIDTH'(i);
                end
            end
        end
    end

    assign is_zero = (den_i.raw == '0);

    always_comb begin
        // Normalize to m in [0.5,1)
        if (lead_pos > MANT_POS) begin
            mant = den_i.raw >> (lead_pos - MANT_POS);
        end else begin
            mant = den_i.raw << (MANT_POS - lead_pos);
        end
        slope = SEED_C1 * mant;
        guess = SEED_C0 - slope[Q_WIDTH+FRAC_BITS-1:FRAC_BITS];

        // Undo the normalization with the opposite exponent
        if (lead_pos > MANT_POS) begin
            wide = {{FRAC_BITS{1'b0}}, guess} >> (lead_pos - MANT_POS);
        end else begin
            wide = {{FRAC_BITS{1'b0}}, guess} << (MANT_POS - lead_pos);
        end

        if (is_zero || (wide[Q_WIDTH+FRAC_BITS-1:Q_WIDTH] != '0)) begin
            seed_d.raw = Q_MAX;
        end else begin
            seed_d.raw = wide[Q_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            seed_q.raw <= '0;
        end else if (start_i) begin
            seed_q <= seed_d;
        end
    end

    assign seed_o = seed_q;

endmodule

// ==== src/sfm_acc_sum.sv ====
// ---------------------------------------------------------------------------
// Running sum saturates at Q_MAX once the integer part overflows
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sfm_acc_sum import sfm_acc_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic        start_new_i,
    input  logic        add_valid_i,
    input  fixed_word_u add_i,
    input  logic        ready_i,
    output fixed_word_u sum_o
);

    fixed_word_u          sum_q;
    fixed_word_u          base;
    fixed_word_u          sum_d;
    logic [FRAC_BITS:0]   frac_sum;
    logic [INT_BITS:0]    int_sum;
    logic                 accept;

    assign accept = en_i & ready_i & add_valid_i;

    always_comb begin
        // A new run adds the first term to zero
        base.raw = start_new_i ? '0 : sum_q.raw;
        frac_sum = {1'b0, base.fld.frac_part} + {1'b0, add_i.fld.frac_part};
        int_sum  = {1'b0, base.fld.int_part} + {1'b0, add_i.fld.int_part}
                 + {{INT_BITS{1'b0}}, frac_sum[FRAC_BITS]};
        if (int_sum[INT_BITS]) begin
            sum_d.raw = Q_MAX;
        end else begin
            sum_d.fld.int_part  = int_sum[INT_BITS-1:0];
            sum_d.fld.frac_part = frac_sum[FRAC_BITS-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sum_q.raw <= '0;
        end else if (clear_i) begin
            sum_q.raw <= '0;
        end else if (accept) begin
            sum_q <= sum_d;
        end
    end

    assign sum_o = sum_q;

endmodule

// ==== src/sfm_accumulator.sv ====
// ---------------------------------------------------------------------------
// Softmax denominator and its reciprocal. Inputs are non-negative Q16.16
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sfm_accumulator import sfm_acc_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        add_valid_i,
    input  fixed_word_u add_i,
    output logic        ready_o,
    input  logic        finish_i,
    input  logic        acc_only_i,
    output logic        acc_done_o,
    output fixed_word_u sum_o,
    output logic        valid_o,
    output fixed_word_u recip_o
);

    logic        acc_en;
    logic        start_new;
    logic        inv_start;
    logic        inv_done;
    fixed_word_u sum;

    sfm_acc_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .add_valid_i (add_valid_i),
        .finish_i    (finish_i),
        .acc_only_i  (acc_only_i),
        .inv_done_i  (inv_done),
        .ready_o     (ready_o),
        .acc_en_o    (acc_en),
        .start_new_o (start_new),
        .inv_start_o (inv_start),
        .acc_done_o  (acc_done_o),
        .valid_o     (valid_o)
    );

    sfm_acc_sum u_sum (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .en_i        (acc_en),
        .start_new_i (start_new),
        .add_valid_i (add_valid_i),
        .add_i       (add_i),
        .ready_i     (ready_o),
        .sum_o       (sum)
    );

    // Sum stays stable through inversion, so it feeds the divider directly
    sfm_acc_newton u_newton (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .start_i (inv_start),
        .den_i   (sum),
        .done_o  (inv_done),
        .recip_o (recip_o)
    );

    assign sum_o = sum;

endmodule

// ==== tests/sfm_acc_testdata.txt ====
# mode count addend... expected_sum expected_recip, every field in hex, data is Q16.16
# mode 0 inverts, mode 1 stops after the sum, mode 2 clears before finish (recip unused)
0 4 00004000 00004000 00004000 00004000 00010000 00010000
0 3 00008000 00010000 00008000 00020000 00008000
1 3 00012345 00003456 00100000 0011579b 00000000
0 5 00001000 00002000 00003000 00004000 0000a000 00014000 0000cccd
2 3 00007000 00009000 00011000 00021000 00000000
0 2 00030000 00020000 00050000 00003333
# Saturating run, only the sum is checked
1 3 c0000000 50000000 00000001 ffffffff 00000000
0 6 00008000 00008000 00008000 00008000 00008000 00008000 00030000 00005555
0 1 00008000 00008000 00020000
0 4 00001234 00002dcc 00004000 00004000 0000c000 00015555
1 2 00018000 00024000 0003c000 00000000
0 3 0000abcd 00015433 00008000 00028000 00006666
0 8 0000c000 0000c000 0000c000 0000c000 0000c000 0000c000 0000c000 0000c000 00060000 00002aab
0 2 00001800 00000800 00002000 00080000
2 2 00002000 00003000 00005000 00000000
0 3 00010000 00004000 00004000 00018000 0000aaab

// ==== tests/tb_sfm_accumulator.sv ====
// ---------------------------------------------------------------------------
// Reads tests/sfm_acc_testdata.txt relative to the project root
// Inputs change on falling edges, outputs are read 10 ns before the rising edge
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_sfm_accumulator import sfm_acc_pkg::*; ();

    localparam int    CLK_PERIOD  = 100;
    localparam int    SAMPLE_OFS  = 40;
    localparam int    TERM_CYCLES = 4;
    localparam int    CASE_CYCLES = 40;
    localparam int    MODE_FULL   = 0;
    localparam int    MODE_ACC    = 1;
    localparam int    MODE_CLEAR  = 2;
    localparam real   REL_TOL     = 1.0 / 4096.0;
    localparam string DATA_FILE   = "tests/sfm_acc_testdata.txt";

    logic        clk_i;
    logic        rst_ni;
    logic        clear_i;
    logic        add_valid_i;
    fixed_word_u add_i;
    logic        ready_o;
    logic        finish_i;
    logic        acc_only_i;
    logic        acc_done_o;
    fixed_word_u sum_o;
    logic        valid_o;
    fixed_word_u recip_o;

    int          seed;
    int          sum_errs;
    int          recip_errs;
    int          flag_errs;
    int          other_errs;
    time         wd_limit;

    int          case_mode [$];
    int          case_cnt [$];
    int          case_base [$];
    fixed_word_u addend_q [$];
    fixed_word_u sum_exp_q [$];
    fixed_word_u recip_exp_q [$];

    sfm_accumulator dut0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .add_valid_i (add_valid_i),
        .add_i       (add_i),
        .ready_o     (ready_o),
        .finish_i    (finish_i),
        .acc_only_i  (acc_only_i),
        .acc_done_o  (acc_done_o),
        .sum_o       (sum_o),
        .valid_o     (valid_o),
        .recip_o     (recip_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_sum(input fixed_word_u got, input fixed_word_u exp);
        if (got.raw !== exp.raw) begin
            $display("** Error at %0d ns: sum_o = %h, expected %h", $time, got.raw, exp.raw);
            sum_errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            flag_errs++;
        end
    endtask

    task automatic check_recip(input fixed_word_u got, input fixed_word_u den,
                               input fixed_word_u listed);
        real         want;
        real         have;
        real         rel;
        longint      diff;
        int unsigned tol;
        want = real'(Q_ONE) / real'(den.raw);
        have = real'(got.raw) / real'(Q_ONE);
        rel  = (have > want) ? (have - want) / want : (want - have) / want;
        if (rel > REL_TOL) begin
            $display("** Error at %0d ns: recip_o = %h (%f), expected %f within 2^-12",
                     $time, got.raw, have, want);
            recip_errs++;
        end
        // Listed value is 1/sum rounded, allow the same relative slack
        diff = longint'(got.raw) - longint'(listed.raw);
        if (diff < 0) begin
            diff = -diff;
        end
        tol = (listed.raw >> 12) + 1;
        if (diff > longint'(tol)) begin
            $display("** Error at %0d ns: recip_o = %h, expected %h", $time, got.raw,
                     listed.raw);
            recip_errs++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        int          mode;
        int          cnt;
        string       tok;
        string       rest;
        logic [31:0] word;
        logic [31:0] recip_word;
        logic [63:0] model;
        fixed_word_u val;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test data file %s", DATA_FILE);
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok.getc(0) == "#") begin
                code = $fgets(rest, fd);
                continue;
            end
            mode = tok.atohex();
            if (mode != MODE_FULL && mode != MODE_ACC && mode != MODE_CLEAR) begin
                $display("Test data case %0d has an unknown mode %0d",
                         case_mode.size(), mode);
                other_errs++;
                break;
            end
            code = $fscanf(fd, "%h", cnt);
            if (code != 1 || cnt < 1) begin
                $display("Test data case %0d has no valid addend count", case_mode.size());
                other_errs++;
                break;
            end
            case_base.push_back(addend_q.size());
            model = '0;
            for (int i = 0; i < cnt; i++) begin
                code = $fscanf(fd, "%h", word);
                val.raw = word;
                addend_q.push_back(val);
                model = model + {32'h0, word};
                if (model > {32'h0, Q_MAX}) begin
                    model = {32'h0, Q_MAX};
                end
            end
            code = $fscanf(fd, "%h %h", word, recip_word);
            if (code != 2) begin
                $display("Test data case %0d ends early", case_mode.size());
                other_errs++;
                break;
            end
            if (model[31:0] !== word) begin
                $display("Test data case %0d lists sum %h but its addends give %h",
                         case_mode.size(), word, model[31:0]);
                other_errs++;
            end
            case_mode.push_back(mode);
            case_cnt.push_back(cnt);
            val.raw = word;
            sum_exp_q.push_back(val);
            val.raw = recip_word;
            recip_exp_q.push_back(val);
        end
        $fclose(fd);
    endtask

    task automatic next_sample();
        @(negedge clk_i);
        #(SAMPLE_OFS);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk_i);
            add_valid_i = 1'b0;
            add_i.raw   = $random(seed);
        end
    endtask

    // Holds the term until ready_o is seen high with it
    task automatic present_term(input fixed_word_u term);
        @(negedge clk_i);
        add_valid_i = 1'b1;
        add_i       = term;
        #(SAMPLE_OFS);
        while (!ready_o) begin
            @(negedge clk_i);
            #(SAMPLE_OFS);
        end
    endtask

    task automatic finish_run(input int mode);
        @(negedge clk_i);
        add_valid_i = 1'b0;
        finish_i    = 1'b1;
        acc_only_i  = (mode == MODE_ACC);
        @(negedge clk_i);
        finish_i    = 1'b0;
        acc_only_i  = (mode != MODE_ACC);
    endtask

    task automatic clear_run(input fixed_word_u partial);
        fixed_word_u zero_word;
        zero_word.raw = '0;
        @(negedge clk_i);
        add_valid_i = 1'b0;
        #(SAMPLE_OFS);
        check_sum(sum_o, partial);
        @(negedge clk_i);
        clear_i = 1'b1;
        @(negedge clk_i);
        clear_i = 1'b0;
        #(SAMPLE_OFS);
        check_sum(sum_o, zero_word);
        check_flag(valid_o, 1'b0, "valid_o");
        check_flag(acc_done_o, 1'b0, "acc_done_o");
        check_flag(ready_o, 1'b1, "ready_o");
    endtask

    task automatic drive_all();
        int gap;
        for (int k = 0; k < case_mode.size(); k++) begin
            for (int i = 0; i < case_cnt[k]; i++) begin
                gap = $unsigned($random(seed)) % 4;
                idle_cycles(gap);
                present_term(addend_q[case_base[k] + i]);
            end
            if (case_mode[k] == MODE_CLEAR) begin
                clear_run(sum_exp_q[k]);
            end else begin
                finish_run(case_mode[k]);
            end
        end
    endtask

    task automatic check_all();
        logic watch_low;
        watch_low = 1'b1;
        for (int k = 0; k < case_mode.size(); k++) begin
            if (case_mode[k] == MODE_CLEAR) begin
                continue;
            end
            next_sample();
            while (!acc_done_o) begin
                // After an accumulate-only run valid_o has to stay low
                if (watch_low) begin
                    check_flag(valid_o, 1'b0, "valid_o");
                end
                next_sample();
            end
            check_sum(sum_o, sum_exp_q[k]);
            check_flag(ready_o, 1'b0, "ready_o");
            next_sample();
            check_flag(acc_done_o, 1'b0, "acc_done_o");
            if (case_mode[k] == MODE_ACC) begin
                check_flag(ready_o, 1'b1, "ready_o");
                check_flag(valid_o, 1'b0, "valid_o");
                watch_low = 1'b1;
            end else begin
                watch_low = 1'b0;
                while (!valid_o) begin
                    check_flag(ready_o, 1'b0, "ready_o");
                    next_sample();
                end
                check_recip(recip_o, sum_exp_q[k], recip_exp_q[k]);
            end
        end
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        clear_i     = 1'b0;
        add_valid_i = 1'b0;
        add_i.raw   = '0;
        finish_i    = 1'b0;
        acc_only_i  = 1'b0;
        seed        = 32'h6071_341b;
        sum_errs    = 0;
        recip_errs  = 0;
        flag_errs   = 0;
        other_errs  = 0;
        wd_limit    = 0;

        load_vectors();
        if (case_mode.size() == 0) begin
            $display("No test cases were read");
            other_errs++;
        end
        wd_limit = time'((addend_q.size() * TERM_CYCLES + case_mode.size() * CASE_CYCLES
                   + 20) * CLK_PERIOD);

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #(SAMPLE_OFS);
        check_flag(ready_o, 1'b1, "ready_o");
        check_flag(acc_done_o, 1'b0, "acc_done_o");
        check_flag(valid_o, 1'b0, "valid_o");

        fork
            drive_all();
            check_all();
        join

        repeat (2) @(negedge clk_i);
        $display("Errors: sum %0d, recip %0d, flag %0d, other %0d",
                 sum_errs, recip_errs, flag_errs, other_errs);
        if (sum_errs + recip_errs + flag_errs + other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        wait (wd_limit != 0);
        #(wd_limit);
        $display("Timeout: the run did not end within %0d ns", wd_limit);
        $display("Something failed");
        $finish;
    end

endmodule
